// File: common/snd_pkg.sv
// Shared types and constants of the sound board glue, referenced by scoped names from every RTL file
`default_nettype none

package snd_pkg;

    // Sound CPU bus outputs, active high inside the design
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq;  // Memory cycle active
        logic        wr;    // Write strobe, one cycle
    } cpu_bus_t;

    // One-hot chip selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic latch0;
        logic latch1;
        logic fm;
        logic pcm;
        logic bank;
        logic rate;
    } sel_t;

    // Program ROM request
    typedef struct packed {
        logic [15:0] addr;
        logic        cs;
    } rom_req_t;

    typedef struct packed {
        logic       start_flag;
        logic [6:0] phrase;
    } pcm_phrase_t;

    typedef struct packed {
        logic [3:0] go;
        logic [3:0] att;    // Right shifts
    } pcm_play_t;

    // Sample player command byte, seen either as phrase select or as play request
    typedef union packed {
        pcm_phrase_t phrase;
        pcm_play_t   play;
    } pcm_cmd_u;

    localparam int FM_DIV       = 14;      // clk cycles per tone enable
    localparam int PCM_DIV      = 48;      // clk cycles per sample enable
    localparam int PHRASE_SHIFT = 11;      // Phrase number position in sample ROM address
    localparam logic [7:0] PCM_END = 8'h80;

endpackage

`default_nettype wire

// File: hdl/snd_cen.sv
// Clock enable generator, divides clk down to the tone and sample enables
`default_nettype none

module snd_cen (
    input  logic clk,
    input  logic rst,
    output logic cen_fm,
    output logic cen_pcm
);

    logic [5:0] div_last [2];   // 6 bits cover both dividers
    logic [5:0] cnt      [2];
    logic [1:0] cen;

    assign div_last[0] = 6'(snd_pkg::FM_DIV - 1);
    assign div_last[1] = 6'(snd_pkg::PCM_DIV - 1);

    for (genvar i = 0; i < 2; i++) begin : g_div
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt[i] <= '0;
                cen[i] <= 1'b0;
            end else begin
                cen[i] <= cnt[i] == div_last[i];   // One-cycle pulse on wrap
                cnt[i] <= (cnt[i] == div_last[i]) ? 6'd0 : cnt[i] + 6'd1;
            end
        end
    end

    assign cen_fm  = cen[0];
    assign cen_pcm = cen[1];

endmodule

`default_nettype wire

// File: hdl/snd_map.sv
// Sound CPU address decoder, builds chip selects and the program ROM address, holds bank and rate
`default_nettype none

module snd_map (
    input  logic              clk,
    input  logic              rst,
    input  snd_pkg::cpu_bus_t cpu,
    output snd_pkg::sel_t     sel,
    output snd_pkg::rom_req_t rom,
    output logic              rate
);

    logic bank;

    always_comb begin
        sel = '0;
        rom = '0;
        if (cpu.mreq) begin
            casez (cpu.addr[15:12])
                4'b0???: begin  // Fixed ROM area
                    sel.rom  = 1'b1;
                    rom.cs   = 1'b1;
                    rom.addr = {1'b0, cpu.addr[14:0]};
                end
                4'b10??: begin  // Banked window
                    sel.rom  = 1'b1;
                    rom.cs   = 1'b1;
                    rom.addr = {1'b1, bank, cpu.addr[13:0]};
                end
                4'hd: sel.ram = 1'b1;
                4'hf: begin
                    // I/O page, registers on odd/even pairs
                    case (cpu.addr[3:1])
                        3'd0:    sel.fm     = 1'b1;
                        3'd1:    sel.pcm    = 1'b1;
                        3'd2:    sel.bank   = 1'b1;
                        3'd3:    sel.rate   = 1'b1;
                        3'd4:    sel.latch0 = 1'b1;
                        3'd5:    sel.latch1 = 1'b1;
                        default: ;      // Unmapped, reads FF
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= 1'b0;
            rate <= 1'b0;
        end else begin
            if (sel.bank && cpu.wr) bank <= cpu.dout[0];
            if (sel.rate && cpu.wr) rate <= cpu.dout[0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/snd_din_mux.sv
// Read data path back to the sound CPU, registered in two stages
`default_nettype none

module snd_din_mux (
    input  logic          clk,
    input  snd_pkg::sel_t sel,
    input  logic [7:0]    latch0,
    input  logic [7:0]    latch1,
    input  logic [7:0]    fm_dout,
    input  logic [7:0]    pcm_dout,
    input  logic [7:0]    ram_dout,
    input  logic [7:0]    rom_data,
    output logic [7:0]    cpu_din
);

    logic [7:0] dev_q, latch_q, mem_q;
    logic       dev_v, latch_v, mem_v;

    // First stage narrows each group to one byte
    always_ff @(posedge clk) begin
        dev_q   <= sel.fm ? fm_dout : pcm_dout;
        dev_v   <= sel.fm | sel.pcm;
        latch_q <= sel.latch0 ? latch0 : latch1;
        latch_v <= sel.latch0 | sel.latch1;
        mem_q   <= sel.ram ? ram_dout : rom_data;
        mem_v   <= sel.ram | sel.rom;
    end

    // Second stage, device wins over latch over memory
    always_ff @(posedge clk) begin
        if (dev_v)
            cpu_din <= dev_q;
        else if (latch_v)
            cpu_din <= latch_q;
        else if (mem_v)
            cpu_din <= mem_q;
        else
            cpu_din <= 8'hff;   // Open bus
    end

endmodule

`default_nettype wire

// File: hdl/snd_ram.sv
// 2 KB work RAM of the sound CPU, synchronous write and read
`default_nettype none

module snd_ram (
    input  logic        clk,
    input  logic        we,
    input  logic [10:0] addr,
    input  logic [7:0]  din,
    output logic [7:0]  q
);

    logic [7:0] mem [2048];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= din;
        q <= mem[addr];     // Old data on a write cycle
    end

endmodule

`default_nettype wire

// File: hdl/snd_mixer.sv
// Output mixer, adds tone and sample sound per channel and registers the result
`default_nettype none

module snd_mixer (
    input  logic               clk,
    input  logic               enable_fm,
    input  logic               enable_adpcm,
    input  logic signed [15:0] fm_left,
    input  logic signed [15:0] fm_right,
    input  logic signed [13:0] pcm,
    output logic signed [15:0] left,
    output logic signed [15:0] right
);

    function automatic logic signed [15:0] mix(input logic signed [15:0] fm);
        logic signed [15:0] fm_t;
        logic signed [15:0] pcm_t;
        fm_t  = enable_fm ? {fm[15], fm[15:1]} : 16'sd0;             // Half scale
        pcm_t = enable_adpcm ? {pcm[13], pcm, pcm[12]} : 16'sd0;    // Stretch to 16 bits
        return fm_t + pcm_t;
    endfunction

    always_ff @(posedge clk) begin
        left  <= mix(fm_left);
        right <= mix(fm_right);
    end

endmodule

`default_nettype wire

// File: tone/tone_gen.sv
// Square-wave tone source behind an index/data register port, with timer interrupt and sample strobe
`default_nettype none

module tone_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               cs,
    input  logic               wr,
    input  logic               a0,
    input  logic [7:0]         din,
    output logic [7:0]         dout,
    output logic               irq_n,
    output logic               sample,
    output logic signed [15:0] left,
    output logic signed [15:0] right
);

    logic [2:0]  idx;           // Selected register
    logic [11:0] period, per_cnt;
    logic [6:0]  lvl_l, lvl_r;  // 7 bits keep level*256 inside the signed word
    logic [7:0]  tmr_reload, tmr_cnt;
    logic        irq_en, irq_flag, sq;
    logic        wr_idx, wr_dat;
    logic [15:0] word_l, word_r;

    assign wr_idx = cs & wr & ~a0;
    assign wr_dat = cs & wr & a0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx        <= '0;
            period     <= '0;
            per_cnt    <= '0;
            lvl_l      <= '0;
            lvl_r      <= '0;
            tmr_reload <= '0;
            tmr_cnt    <= '0;
            irq_en     <= 1'b0;
            irq_flag   <= 1'b0;
            sq         <= 1'b0;
            sample     <= 1'b0;
        end else begin
            sample <= cen;
            if (wr_idx) idx <= din[2:0];
            if (cen) begin
                if (per_cnt == 12'd0) begin
                    per_cnt <= period;
                    sq      <= ~sq;
                end else begin
                    per_cnt <= per_cnt - 12'd1;
                end
                // Reload of 0 leaves the timer stopped
                if (tmr_cnt == 8'd0) begin
                    tmr_cnt <= tmr_reload;
                end else begin
                    tmr_cnt <= tmr_cnt - 8'd1;
                    if (tmr_cnt == 8'd1 && irq_en) irq_flag <= 1'b1;
                end
            end
            if (wr_dat) begin
                case (idx)
                    3'd0: period[7:0]  <= din;
                    3'd1: period[11:8] <= din[3:0];
                    3'd2: lvl_l        <= din[6:0];
                    3'd3: lvl_r        <= din[6:0];
                    3'd4: tmr_reload   <= din;
                    3'd5: begin
                        irq_en   <= din[0];
                        irq_flag <= 1'b0;   // Acknowledge
                    end
                    default: ;
                endcase
            end
        end
    end

    assign dout  = {7'd0, irq_flag};
    assign irq_n = ~irq_flag;

    assign word_l = {1'b0, lvl_l, 8'h00};
    assign word_r = {1'b0, lvl_r, 8'h00};
    assign left   = sq ? $signed(word_l) : -$signed(word_l);
    assign right  = sq ? $signed(word_r) : -$signed(word_r);

endmodule

`default_nettype wire

// File: pcm/pcm_player.sv
// Signed 8-bit PCM sample player, takes phrase/play commands and fetches bytes from the sample ROM
`default_nettype none

module pcm_player (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               rate,
    input  logic               cs,
    input  logic               wr,
    input  logic [7:0]         din,
    output logic [7:0]         dout,
    output logic [17:0]        rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output logic signed [13:0] sound
);

    typedef enum logic [1:0] {ST_IDLE, ST_PLAY, ST_FETCH} st_t;

    st_t               st;
    snd_pkg::pcm_cmd_u cmd;
    logic [6:0]        phrase;
    logic [3:0]        att;
    logic [17:0]       ptr;         // Next byte to fetch
    logic              armed;       // Phrase received, waiting for play
    logic              half, tick, fetch_busy;
    logic              stop_pend, restart;

    assign cmd        = din;
    assign tick       = cen & (~rate | half);     // Half rate when rate is set
    assign fetch_busy = (st == ST_FETCH) & ~rom_ok;
    assign dout       = {7'd0, st != ST_IDLE};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= ST_IDLE;
            rom_cs    <= 1'b0;
            rom_addr  <= '0;
            ptr       <= '0;
            phrase    <= '0;
            att       <= '0;
            armed     <= 1'b0;
            half      <= 1'b0;
            stop_pend <= 1'b0;
            restart   <= 1'b0;
            sound     <= '0;
        end else begin
            if (cen) half <= ~half;
            case (st)
                ST_PLAY: if (tick) begin
                    rom_cs    <= 1'b1;
                    rom_addr  <= ptr;
                    stop_pend <= 1'b0;
                    restart   <= 1'b0;
                    st        <= ST_FETCH;
                end
                ST_FETCH: if (rom_ok) begin
                    rom_cs <= 1'b0;
                    if (stop_pend || (!restart && rom_data == snd_pkg::PCM_END)) begin
                        st    <= ST_IDLE;
                        sound <= '0;
                    end else begin
                        st <= ST_PLAY;
                        if (!restart) begin     // Data of a replaced phrase is dropped
                            sound <= $signed({rom_data, 6'd0}) >>> att;
                            ptr   <= ptr + 18'd1;
                        end
                    end
                end
                default: ;
            endcase
            // Commands override the sequencer, but never cut a pending ROM access
            if (cs && wr) begin
                if (cmd.phrase.start_flag) begin
                    phrase <= cmd.phrase.phrase;
                    armed  <= 1'b1;
                end else if (cmd.play.go == 4'd0) begin
                    armed   <= 1'b0;
                    restart <= 1'b0;
                    if (fetch_busy) begin
                        stop_pend <= 1'b1;
                    end else begin
                        st     <= ST_IDLE;
                        rom_cs <= 1'b0;
                        sound  <= '0;
                    end
                end else if (armed) begin
                    armed     <= 1'b0;
                    att       <= cmd.play.att;
                    ptr       <= 18'(phrase) << snd_pkg::PHRASE_SHIFT;
                    stop_pend <= 1'b0;
                    if (fetch_busy) begin
                        restart <= 1'b1;
                    end else begin
                        st     <= ST_PLAY;
                        rom_cs <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/snd_top.sv
// Sound board glue top level, the sound CPU bus enters as a port struct
`default_nettype none

module snd_top (
    input  logic               clk,
    input  logic               rst,
    input  snd_pkg::cpu_bus_t  cpu,
    output logic [7:0]         cpu_din,
    output logic               irq_n,
    input  logic [7:0]         snd_latch0,
    input  logic [7:0]         snd_latch1,
    input  logic               enable_fm,
    input  logic               enable_adpcm,
    output snd_pkg::rom_req_t  rom,
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,      // Used by the CPU, which holds the bus meanwhile
    output logic [17:0]        adpcm_addr,
    output logic               adpcm_cs,
    input  logic [7:0]         adpcm_data,
    input  logic               adpcm_ok,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    snd_pkg::sel_t      sel;
    logic               rate, cen_fm, cen_pcm;
    logic [7:0]         fm_dout, pcm_dout, ram_dout;
    logic signed [15:0] fm_left, fm_right;
    logic signed [13:0] pcm_snd;

    snd_cen u_cen (.clk(clk), .rst(rst), .cen_fm(cen_fm), .cen_pcm(cen_pcm));

    snd_map u_map (.clk(clk), .rst(rst), .cpu(cpu), .sel(sel), .rom(rom), .rate(rate));

    snd_ram u_ram (
        .clk  (clk),
        .we   (sel.ram & cpu.wr),
        .addr (cpu.addr[10:0]),
        .din  (cpu.dout),
        .q    (ram_dout)
    );

    snd_din_mux u_din (
        .clk      (clk),         .sel      (sel),
        .latch0   (snd_latch0),  .latch1   (snd_latch1),
        .fm_dout  (fm_dout),     .pcm_dout (pcm_dout),
        .ram_dout (ram_dout),    .rom_data (rom_data),
        .cpu_din  (cpu_din)
    );

    tone_gen u_tone (
        .clk   (clk),       .rst    (rst),      .cen   (cen_fm),
        .cs    (sel.fm),    .wr     (cpu.wr),   .a0    (cpu.addr[0]),
        .din   (cpu.dout),  .dout   (fm_dout),  .irq_n (irq_n),
        .sample(sample),    .left   (fm_left),  .right (fm_right)
    );

    pcm_player u_pcm (
        .clk      (clk),         .rst      (rst),       .cen     (cen_pcm),
        .rate     (rate),        .cs       (sel.pcm),   .wr      (cpu.wr),
        .din      (cpu.dout),    .dout     (pcm_dout),
        .rom_addr (adpcm_addr),  .rom_cs   (adpcm_cs),
        .rom_data (adpcm_data),  .rom_ok   (adpcm_ok),  .sound   (pcm_snd)
    );

    snd_mixer u_mix (
        .clk          (clk),
        .enable_fm    (enable_fm),
        .enable_adpcm (enable_adpcm),
        .fm_left      (fm_left),
        .fm_right     (fm_right),
        .pcm          (pcm_snd),
        .left         (left),
        .right        (right)
    );

endmodule

`default_nettype wire

// File: tb/snd_clk.sv
// Testbench clock and reset source, 40 unit period with reset held for two cycles
`default_nettype none

module snd_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #5 rst = 1'b0;     // Released with the other stimulus
    end

endmodule

`default_nettype wire

// File: tb/snd_chk.sv
// Concurrent assertions on the sound top level, bound into snd_top by the statement at the end
`default_nettype none

module snd_chk (
    input logic          clk,
    input logic          rst,
    input snd_pkg::sel_t sel,
    input logic          irq_n,
    input logic          adpcm_cs,
    input logic          adpcm_ok
);

    int fails = 0;  // Read by the testbench for its summary

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else begin
            $error("More than one chip select active");
            fails++;
        end

    a_irq_reset: assert property (@(posedge clk) rst |-> irq_n)
        else begin
            $error("irq_n low during reset");
            fails++;
        end

    // Sample ROM access is held until acknowledged
    a_cs_hold: assert property (@(posedge clk) disable iff (rst)
        adpcm_cs && !adpcm_ok |=> adpcm_cs)
        else begin
            $error("adpcm_cs dropped before adpcm_ok");
            fails++;
        end

endmodule

bind snd_top snd_chk u_chk (
    .clk(clk), .rst(rst), .sel(sel), .irq_n(irq_n), .adpcm_cs(adpcm_cs), .adpcm_ok(adpcm_ok)
);

`default_nettype wire

// File: tb/snd_tb.sv
// Directed testbench for the sound board glue, acts as the sound CPU and models both ROMs
`default_nettype none

module snd_tb;

    localparam int NUM_TESTS = 6;

    logic               clk, rst, irq_n, enable_fm, enable_adpcm, rom_ok;
    logic               adpcm_cs, adpcm_ok, sample, watch, got_addr;
    logic [7:0]         cpu_din, snd_latch0, snd_latch1, rom_data, adpcm_data;
    logic [17:0]        adpcm_addr, first_addr;
    logic signed [15:0] left, right, last_left;
    logic signed [15:0] seen [$];   // Distinct values of left during playback
    snd_pkg::cpu_bus_t  cpu;
    snd_pkg::rom_req_t  rom, rom_q;
    integer             seed = 56;
    int                 n_val, n_other, rnd;

    snd_clk u_clk (.clk(clk), .rst(rst));
    snd_top dut (.*);

    function automatic logic [7:0] rom_byte(input logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] table_byte(input logic [10:0] off);
        case (off)
            11'd0:   return 8'h40;
            11'd1:   return 8'hc0;
            11'd2:   return 8'h7f;
            11'd3:   return 8'h81;
            default: return snd_pkg::PCM_END;
        endcase
    endfunction

    // Byte times 64, shifted by att, then stretched the way the mixer does
    function automatic logic signed [15:0] pcm_word(input logic [7:0] b, input int att);
        int s;
        s = int'($signed(b)) * 64;
        s = s >>> att;
        return 16'(s * 2 + ((s >>> 12) & 1));
    endfunction

    assign adpcm_data = table_byte(adpcm_addr[10:0]);

    // Program ROM answers one cycle after the request is seen
    always begin
        @(negedge clk);
        rom_q = rom;
        @(posedge clk);
        #5;
        rom_data = rom_byte(rom_q.addr);
        rom_ok   = rom_q.cs;
    end

    always @(posedge clk) begin
        #5;
        rnd      = $random(seed);
        adpcm_ok = rnd[0];
    end

    always @(posedge clk) begin
        #1;
        if (watch && left !== last_left) seen.push_back(left);
        if (watch && adpcm_cs && !got_addr) begin
            first_addr = adpcm_addr;
            got_addr   = 1'b1;
        end
        last_left = left;
    end

    task automatic cmp_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            n_val++;
        end
    endtask

    task automatic cmp_rom(input string name, input snd_pkg::rom_req_t got,
                           input snd_pkg::rom_req_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            n_val++;
        end
    endtask

    task automatic cmp_snd(input string name, input logic signed [15:0] got,
                           input logic signed [15:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            n_val++;
        end
    endtask

    task automatic cmp_addr(input string name, input logic [17:0] got, input logic [17:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            n_val++;
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        #5;
        cpu = '{addr: a, dout: d, mreq: 1'b1, wr: 1'b1};
        @(posedge clk);
        #5;
        cpu = '0;
    endtask

    // Holds the bus while a ROM read is not ready, then samples three cycles later
    task automatic bus_read(input logic [15:0] a, output logic [7:0] d,
                            output snd_pkg::rom_req_t req);
        int n;
        n = 0;
        @(posedge clk);
        #5;
        cpu = '{addr: a, dout: 8'h00, mreq: 1'b1, wr: 1'b0};
        do begin
            @(negedge clk);
            n++;
        end while (rom.cs && !rom_ok && n < 50);
        req = rom;
        if (rom.cs && !rom_ok) begin
            $display("ROM read at %h never got rom_ok", a);
            n_other++;
        end
        repeat (3) @(posedge clk);
        #5;
        d   = cpu_din;
        cpu = '0;
    endtask

    task automatic set_enables(input logic fm, input logic pcm);
        @(posedge clk);
        #5;
        enable_fm    = fm;
        enable_adpcm = pcm;
    endtask

    task automatic tone_reg(input logic [7:0] idx, input logic [7:0] val);
        bus_write(16'hf000, idx);
        bus_write(16'hf001, val);
    endtask

    task automatic wait_pcm_idle();
        logic [7:0]        d;
        snd_pkg::rom_req_t rq;
        int                n;
        n = 0;
        d = 8'h01;
        while (d[0] && n < 400) begin
            bus_read(16'hf002, d, rq);
            n++;
        end
        if (d[0]) begin
            $display("Sample player still busy after %0d status reads", n);
            n_other++;
        end
    endtask

    task automatic rom_check(input logic [15:0] a, input logic [15:0] rom_a);
        logic [7:0]        d;
        snd_pkg::rom_req_t rq;
        bus_read(a, d, rq);
        cmp_rom("rom", rq, '{addr: rom_a, cs: 1'b1});
        cmp_byte("cpu_din", d, rom_byte(rom_a));
    endtask

    task automatic after_reset();
        cmp_byte("irq_n", {7'd0, irq_n}, 8'h01);
        cmp_byte("adpcm_cs", {7'd0, adpcm_cs}, 8'h00);
        cmp_snd("left", left, 16'sd0);
        cmp_snd("right", right, 16'sd0);
    endtask

    task automatic rom_mapping();
        rom_check(16'h1234, 16'h1234);
        rom_check(16'h7abc, 16'h7abc);
        rom_check(16'h8123, 16'h8123);  // Bank 0 after reset
        bus_write(16'hf004, 8'h01);     // Bank 1
        rom_check(16'h9321, 16'hd321);
        rom_check(16'hbfff, 16'hffff);
    endtask

    task automatic ram_and_latches();
        logic [7:0]        d;
        snd_pkg::rom_req_t rq;
        bus_write(16'hd123, 8'ha5);
        bus_write(16'hd7ff, 8'h5a);
        bus_read(16'hd123, d, rq);
        cmp_byte("ram d123", d, 8'ha5);
        bus_read(16'hd7ff, d, rq);
        cmp_byte("ram d7ff", d, 8'h5a);
        bus_read(16'hf008, d, rq);
        cmp_byte("latch0", d, 8'h3c);
        bus_read(16'hf00a, d, rq);
        cmp_byte("latch1", d, 8'hc3);
        bus_read(16'hf00c, d, rq);
        cmp_byte("unmapped", d, 8'hff);
    endtask

    task automatic tone_and_irq();
        logic signed [15:0] exp_l, exp_r;
        logic [7:0]         d;
        snd_pkg::rom_req_t  rq;
        logic               pos, neg;
        int                 pulses, waited;
        pulses = 0;
        waited = 0;
        pos    = 1'b0;
        neg    = 1'b0;
        set_enables(1'b1, 1'b0);
        tone_reg(8'd0, 8'h02);
        tone_reg(8'd1, 8'h00);
        tone_reg(8'd2, 8'h20);
        tone_reg(8'd3, 8'h10);
        repeat (3) @(posedge clk);
        repeat (200) begin
            @(posedge clk);
            #1;
            exp_l = left[15] ? -16'sd4096 : 16'sd4096;      // Level 20h halved
            exp_r = right[15] ? -16'sd2048 : 16'sd2048;
            cmp_snd("left", left, exp_l);
            cmp_snd("right", right, exp_r);
            if (sample) pulses++;
            if (left[15]) neg = 1'b1;
            else pos = 1'b1;
        end
        if (pulses == 0 || !pos || !neg) begin
            $display("Tone did not toggle or sample never pulsed (%0d pulses)", pulses);
            n_other++;
        end
        tone_reg(8'd4, 8'h03);
        tone_reg(8'd5, 8'h01);
        while (irq_n && waited < 2000) begin
            @(negedge clk);
            waited++;
        end
        if (irq_n) begin
            $display("Timer interrupt never asserted");
            n_other++;
        end
        bus_read(16'hf000, d, rq);
        cmp_byte("fm status", d, 8'h01);
        tone_reg(8'd5, 8'h00);  // Acknowledge and disable
        repeat (2) @(posedge clk);
        #1;
        cmp_byte("irq_n", {7'd0, irq_n}, 8'h01);
    endtask

    task automatic sample_playback();
        logic signed [15:0] exp [5];
        exp[0] = pcm_word(8'h40, 2);
        exp[1] = pcm_word(8'hc0, 2);
        exp[2] = pcm_word(8'h7f, 2);
        exp[3] = pcm_word(8'h81, 2);
        exp[4] = 16'sd0;
        set_enables(1'b0, 1'b1);
        repeat (2) @(posedge clk);
        seen.delete();
        got_addr = 1'b0;
        watch    = 1'b1;
        bus_write(16'hf002, 8'h85);     // Phrase 5
        bus_write(16'hf002, 8'h12);     // Go with att 2
        wait_pcm_idle();
        repeat (3) @(posedge clk);
        watch = 1'b0;
        if (seen.size() != 5) begin
            $display("Saw %0d sample values on left instead of 5", seen.size());
            n_other++;
        end else begin
            foreach (exp[i]) cmp_snd("left", seen[i], exp[i]);
        end
        if (!got_addr) begin
            $display("Sample ROM was never accessed");
            n_other++;
        end else begin
            cmp_addr("adpcm_addr", first_addr, 18'h02800);
        end
    endtask

    task automatic muted_outputs();
        set_enables(1'b0, 1'b0);
        bus_write(16'hf002, 8'h85);
        bus_write(16'hf002, 8'h12);
        repeat (300) begin
            @(posedge clk);
            #1;
            cmp_snd("left", left, 16'sd0);
            cmp_snd("right", right, 16'sd0);
        end
        wait_pcm_idle();
    endtask

    initial begin
        cpu          = '0;
        snd_latch0   = 8'h3c;
        snd_latch1   = 8'hc3;
        enable_fm    = 1'b0;
        enable_adpcm = 1'b0;
        rom_data     = 8'h00;
        rom_ok       = 1'b0;
        adpcm_ok     = 1'b0;
        watch        = 1'b0;
        got_addr     = 1'b0;
        n_val        = 0;
        n_other      = 0;
        @(negedge rst);
        after_reset();
        rom_mapping();
        ram_and_latches();
        tone_and_irq();
        sample_playback();
        muted_outputs();
        $display("Errors: %0d value, %0d other, %0d assertion",
                 n_val, n_other, dut.u_chk.fails);
        if (n_val + n_other + dut.u_chk.fails == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 20000);
        $display("Watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/snd_pkg.sv
hdl/snd_cen.sv
hdl/snd_map.sv
hdl/snd_din_mux.sv
hdl/snd_ram.sv
hdl/snd_mixer.sv
tone/tone_gen.sv
pcm/pcm_player.sv
hdl/snd_top.sv
tb/snd_clk.sv
tb/snd_chk.sv
tb/snd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= snd_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS      ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
